/* source/resnet_tail_config.svh */
`ifndef RESNET_TAIL_CONFIG_SVH
`define RESNET_TAIL_CONFIG_SVH

// lanes per feature word and lane width, lanes are signed
`define RT_LANES 16
`define RT_LANE_W 16

// signed stage weight, RT_FRAC fraction bits
`define RT_WEIGHT_W 8
`define RT_FRAC 4

// residual stages in the chain
`define RT_STAGES 4

// words per frame and the width of the word address
`define RT_FRAME_WORDS 8
`define RT_ADDR_W 3

// half of a feature word, as handed out by egress
`define RT_HALF_W (`RT_LANES * `RT_LANE_W / 2)

`endif

/* source/resnet_tail_pkg.sv */
`include "resnet_tail_config.svh"

package resnet_tail_pkg;

  typedef logic signed [`RT_LANE_W-1:0] lane_t;

  typedef logic signed [`RT_WEIGHT_W-1:0] weight_t;

  // selects the stage whose weight is written
  typedef logic [$clog2(`RT_STAGES)-1:0] stage_idx_t;

  // upper half holds lanes 8 to 15, lower half lanes 0 to 7
  typedef struct packed {
    logic [`RT_HALF_W-1:0] upper;
    logic [`RT_HALF_W-1:0] lower;
  } feature_halves_t;

  // stages work on lanes, egress on the two halves
  typedef union packed {
    lane_t [`RT_LANES-1:0] lanes;
    feature_halves_t       halves;
  } feature_word_t;

endpackage

/* source/feature_ingress.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module feature_ingress
  import resnet_tail_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  in_valid,
  output logic                  in_ready,
  input  feature_word_t         in_data,

  input  logic                  advance,

  output logic                  s0_valid,
  output feature_word_t         s0_data,
  output logic [`RT_ADDR_W-1:0] s0_addr,
  output logic                  s0_last
);

  localparam logic [`RT_ADDR_W-1:0] LastWord = `RT_ADDR_W'(`RT_FRAME_WORDS - 1);

  logic [`RT_ADDR_W-1:0] word_cnt;
  logic                  take;

  // the slice frees up when empty or when stage 0 takes its word
  assign in_ready = !s0_valid || advance;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s0_valid <= 1'b0;
    end else if (in_ready) begin
      s0_valid <= in_valid;
    end
  end

  // position of the next word inside its frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_cnt <= '0;
    end else if (take) begin
      if (word_cnt == LastWord) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      s0_data <= in_data;
      s0_addr <= word_cnt;
      s0_last <= (word_cnt == LastWord);
    end
  end

endmodule

/* source/stage_sequencer.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module stage_sequencer
  import resnet_tail_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   s0_valid,
  input  logic [`RT_ADDR_W-1:0]  s0_addr,
  input  logic                   s0_last,

  input  logic                   egress_ready,

  input  logic                   cfg_valid,
  input  stage_idx_t             cfg_stage,

  output logic                   advance,
  output logic [`RT_STAGES-1:0]  stage_en,
  output logic [`RT_STAGES-1:0]  weight_we,
  output logic                   cfg_busy,

  output logic                   fin_valid,
  output logic [`RT_ADDR_W-1:0]  fin_addr,
  output logic                   fin_last
);

  // valid, address and last per stage output position
  logic [`RT_STAGES-1:0] stage_vld;
  logic [`RT_ADDR_W-1:0] addr_pipe [`RT_STAGES];
  logic [`RT_STAGES-1:0] last_pipe;
  logic [`RT_STAGES-1:0] stage_in_vld;

  // mirrors the egress output register
  logic                  egress_full;

  // the whole chain moves only when the sink can take the last stage
  assign advance      = egress_ready;
  assign stage_in_vld = {stage_vld[`RT_STAGES-2:0], s0_valid};
  assign stage_en     = stage_in_vld & {`RT_STAGES{advance}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_vld   <= '0;
      egress_full <= 1'b0;
    end else if (advance) begin
      stage_vld   <= stage_in_vld;
      egress_full <= stage_vld[`RT_STAGES-1];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      addr_pipe[0] <= s0_addr;
      for (int k = 1; k < `RT_STAGES; k++) begin
        addr_pipe[k] <= addr_pipe[k-1];
      end
      last_pipe <= {last_pipe[`RT_STAGES-2:0], s0_last};
    end
  end

  assign fin_valid = stage_vld[`RT_STAGES-1];
  assign fin_addr  = addr_pipe[`RT_STAGES-1];
  assign fin_last  = last_pipe[`RT_STAGES-1];

  assign cfg_busy = s0_valid || (|stage_vld) || egress_full;

  // weights change only with an empty chain
  always_comb begin
    weight_we = '0;
    if (cfg_valid && !cfg_busy) begin
      weight_we[cfg_stage] = 1'b1;
    end
  end

endmodule

/* source/residual_stage.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module residual_stage
  import resnet_tail_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,

  input  logic          en,

  input  logic          weight_we,
  input  weight_t       weight_in,

  input  feature_word_t in_word,
  output feature_word_t out_word
);

  localparam int ProdW = `RT_LANE_W + `RT_WEIGHT_W;
  localparam int LaneMax = 2 ** (`RT_LANE_W - 1) - 1;

  weight_t       weight_q;
  feature_word_t next_word;

  // relu(sat((x * w) >>> frac + x)) for one lane
  function automatic lane_t stage_lane(lane_t x, weight_t w);
    logic signed [ProdW-1:0] prod;
    logic signed [ProdW-1:0] scaled;
    logic signed [ProdW:0]   sum;
    lane_t                   res;
    prod   = x * w;
    scaled = prod >>> `RT_FRAC;
    // skip path added back after the rescale
    sum    = scaled + x;
    if (sum < 0) begin
      res = '0;
    end else if (sum > LaneMax) begin
      res = lane_t'(LaneMax);
    end else begin
      res = sum[`RT_LANE_W-1:0];
    end
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      weight_q <= '0;
    end else if (weight_we) begin
      weight_q <= weight_in;
    end
  end

  always_comb begin
    next_word = in_word;
    for (int i = 0; i < `RT_LANES; i++) begin
      next_word.lanes[i] = stage_lane(in_word.lanes[i], weight_q);
    end
  end

  // data only, the valid bit lives in the sequencer
  always_ff @(posedge clk) begin
    if (en) begin
      out_word <= next_word;
    end
  end

endmodule

/* source/result_egress.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module result_egress
  import resnet_tail_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fin_valid,
  input  feature_word_t         fin_word,
  input  logic [`RT_ADDR_W-1:0] fin_addr,
  input  logic                  fin_last,
  output logic                  egress_ready,

  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`RT_HALF_W-1:0] out_lo,
  output logic [`RT_HALF_W-1:0] out_hi,
  output logic [`RT_ADDR_W-1:0] out_addr,
  output logic                  out_last
);

  feature_word_t word_q;

  // register frees when empty or when the sink takes it this cycle
  assign egress_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (egress_ready) begin
      out_valid <= fin_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (egress_ready && fin_valid) begin
      word_q   <= fin_word;
      out_addr <= fin_addr;
      out_last <= fin_last;
    end
  end

  // lanes 0 to 7 go out on out_lo
  assign out_lo = word_q.halves.lower;
  assign out_hi = word_q.halves.upper;

endmodule

/* source/resnet_tail.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module resnet_tail
  import resnet_tail_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  in_valid,
  output logic                  in_ready,
  input  feature_word_t         in_data,

  input  logic                  cfg_valid,
  input  stage_idx_t            cfg_stage,
  input  weight_t               cfg_weight,
  output logic                  cfg_busy,

  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`RT_HALF_W-1:0] out_lo,
  output logic [`RT_HALF_W-1:0] out_hi,
  output logic [`RT_ADDR_W-1:0] out_addr,
  output logic                  out_last
);

  logic                  advance;
  logic                  egress_ready;
  logic                  s0_valid;
  logic [`RT_ADDR_W-1:0] s0_addr;
  logic                  s0_last;
  logic [`RT_STAGES-1:0] stage_en;
  logic [`RT_STAGES-1:0] weight_we;
  logic                  fin_valid;
  logic [`RT_ADDR_W-1:0] fin_addr;
  logic                  fin_last;

  // chain[0] is the ingress word, chain[k+1] the output of stage k
  feature_word_t         chain [`RT_STAGES+1];

  feature_ingress i_ingress (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .advance  (advance),
    .s0_valid (s0_valid),
    .s0_data  (chain[0]),
    .s0_addr  (s0_addr),
    .s0_last  (s0_last)
  );

  stage_sequencer i_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .s0_valid     (s0_valid),
    .s0_addr      (s0_addr),
    .s0_last      (s0_last),
    .egress_ready (egress_ready),
    .cfg_valid    (cfg_valid),
    .cfg_stage    (cfg_stage),
    .advance      (advance),
    .stage_en     (stage_en),
    .weight_we    (weight_we),
    .cfg_busy     (cfg_busy),
    .fin_valid    (fin_valid),
    .fin_addr     (fin_addr),
    .fin_last     (fin_last)
  );

  for (genvar k = 0; k < `RT_STAGES; k++) begin : g_stage
    residual_stage i_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .en        (stage_en[k]),
      .weight_we (weight_we[k]),
      .weight_in (cfg_weight),
      .in_word   (chain[k]),
      .out_word  (chain[k+1])
    );
  end

  result_egress i_egress (
    .clk          (clk),
    .rst_n        (rst_n),
    .fin_valid    (fin_valid),
    .fin_word     (chain[`RT_STAGES]),
    .fin_addr     (fin_addr),
    .fin_last     (fin_last),
    .egress_ready (egress_ready),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_lo       (out_lo),
    .out_hi       (out_hi),
    .out_addr     (out_addr),
    .out_last     (out_last)
  );

endmodule

/* tb/tb_resnet_tail_vectors.svh */
`ifndef TB_RESNET_TAIL_VECTORS_SVH
`define TB_RESNET_TAIL_VECTORS_SVH

localparam int WordW   = `RT_LANES * `RT_LANE_W;
localparam int LaneMax = (1 << (`RT_LANE_W - 1)) - 1;

// lane i sits at bits 16*i, so lanes 0 to 7 form the low half
typedef logic [WordW-1:0] word_bits_t;

typedef enum logic [1:0] {PatMixed, PatLarge, PatRandom} pattern_e;
typedef enum logic {BpNone, BpRandom} backpressure_e;

typedef struct packed {
  weight_t       w0;
  weight_t       w1;
  weight_t       w2;
  weight_t       w3;
  pattern_e      pattern;
  backpressure_e bp;
  logic          check_timing;
  logic          busy_write;
} vector_t;

localparam int NumTests = 6;

// weights of stage 0 to 3, lanes, sink, timing check, write while busy
// the first entry runs on the reset weights
localparam vector_t Vectors [NumTests] = '{
  '{8'sd0,   8'sd0,   8'sd0,   8'sd0,   PatMixed,  BpNone,   1'b0, 1'b0},
  '{-8'sd24, 8'sd20,  -8'sd6,  8'sd9,   PatMixed,  BpNone,   1'b0, 1'b0},
  '{8'sd127, 8'sd127, 8'sd127, 8'sd127, PatLarge,  BpNone,   1'b0, 1'b0},
  '{8'sd16,  -8'sd8,  8'sd3,   8'sd7,   PatRandom, BpRandom, 1'b0, 1'b0},
  '{8'sd2,   8'sd1,   -8'sd1,  8'sd4,   PatRandom, BpNone,   1'b1, 1'b0},
  '{8'sd10,  -8'sd5,  8'sd7,   8'sd2,   PatMixed,  BpNone,   1'b0, 1'b1}
};

string test_names [NumTests] = '{
  "relu_reset_weights", "programmed_weights", "saturation",
  "random_backpressure", "streaming_latency", "write_while_busy"
};

// stage 1 at -128 would turn every positive lane into zero
localparam stage_idx_t RejectStage  = 2'd1;
localparam weight_t    RejectWeight = weight_t'(-128);
localparam int         RejectAtWord = 4;

function automatic word_bits_t apply_stage(word_bits_t x, weight_t w);
  word_bits_t y;
  int         lane;
  int         v;
  for (int i = 0; i < `RT_LANES; i++) begin
    lane = int'($signed(x[i*`RT_LANE_W +: `RT_LANE_W]));
    v    = ((lane * int'(w)) >>> `RT_FRAC) + lane;
    if (v < 0) begin
      v = 0;
    end else if (v > LaneMax) begin
      v = LaneMax;
    end
    y[i*`RT_LANE_W +: `RT_LANE_W] = v[`RT_LANE_W-1:0];
  end
  return y;
endfunction

function automatic word_bits_t expect_word(word_bits_t x, vector_t v);
  word_bits_t y;
  y = apply_stage(x, v.w0);
  y = apply_stage(y, v.w1);
  y = apply_stage(y, v.w2);
  y = apply_stage(y, v.w3);
  return y;
endfunction

function automatic word_bits_t make_word(pattern_e pattern, int idx);
  word_bits_t word;
  int         v;
  for (int i = 0; i < `RT_LANES; i++) begin
    case (pattern)
      PatMixed: v = (((i * 7 + idx * 3) % 17) - 8) * 1901;
      PatLarge: v = 20000 + i * 700 + idx * 13;
      default:  v = int'($urandom);
    endcase
    word[i*`RT_LANE_W +: `RT_LANE_W] = v[`RT_LANE_W-1:0];
  end
  return word;
endfunction

`endif

/* tb/tb_resnet_tail.sv */
`timescale 1ns/1ps
`include "resnet_tail_config.svh"

module tb_resnet_tail
  import resnet_tail_pkg::*;
();

  localparam int WaitLimit = 400;
  // one register each for ingress, every stage and egress
  localparam int Latency = `RT_STAGES + 2;
  localparam logic [`RT_ADDR_W-1:0] LastAddr = `RT_ADDR_W'(`RT_FRAME_WORDS - 1);

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  feature_word_t         in_data;
  logic                  cfg_valid;
  stage_idx_t            cfg_stage;
  weight_t               cfg_weight;
  logic                  cfg_busy;
  logic                  out_valid;
  logic                  out_ready;
  logic [`RT_HALF_W-1:0] out_lo;
  logic [`RT_HALF_W-1:0] out_hi;
  logic [`RT_ADDR_W-1:0] out_addr;
  logic                  out_last;

  `include "tb_resnet_tail_vectors.svh"

  word_bits_t            exp_q [$];
  backpressure_e         bp_mode = BpNone;
  int                    cyc = 0;
  int                    checks = 0;
  int                    errors = 0;
  logic                  hung = 1'b0;
  string                 hung_what;

  // per test timing
  logic                  seen_first = 1'b0;
  int                    first_xfer_cyc;
  int                    first_out_cyc;
  int                    run_len = 0;
  int                    max_run = 0;
  logic [`RT_ADDR_W-1:0] out_cnt = '0;

  // output seen on a stalled cycle
  logic                  held = 1'b0;
  logic [`RT_HALF_W-1:0] held_lo;
  logic [`RT_HALF_W-1:0] held_hi;
  logic [`RT_ADDR_W-1:0] held_addr;
  logic                  held_last;

  resnet_tail i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .cfg_valid  (cfg_valid),
    .cfg_stage  (cfg_stage),
    .cfg_weight (cfg_weight),
    .cfg_busy   (cfg_busy),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_lo     (out_lo),
    .out_hi     (out_hi),
    .out_addr   (out_addr),
    .out_last   (out_last)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_value(string name, logic [127:0] got, logic [127:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic score_output();
    word_bits_t want;
    if (exp_q.size() == 0) begin
      errors++;
      $display("an output word came out at %0t ns with no word expected", $time);
    end else begin
      want = exp_q.pop_front();
      check_value("out_lo", out_lo, want[`RT_HALF_W-1:0]);
      check_value("out_hi", out_hi, want[WordW-1:`RT_HALF_W]);
      check_value("out_addr", 128'(out_addr), 128'(out_cnt));
      check_value("out_last", 128'(out_last), 128'(out_cnt == LastAddr));
      out_cnt++;
    end
  endtask

  // sink side, sampled away from the clock edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (held) begin
        check_value("stalled out_valid", 128'(out_valid), 128'(1'b1));
        check_value("stalled out_lo", out_lo, held_lo);
        check_value("stalled out_hi", out_hi, held_hi);
        check_value("stalled out_addr", 128'(out_addr), 128'(held_addr));
        check_value("stalled out_last", 128'(out_last), 128'(held_last));
      end
      if (out_valid && !seen_first) begin
        seen_first    = 1'b1;
        first_out_cyc = cyc;
      end
      run_len = out_valid ? run_len + 1 : 0;
      if (run_len > max_run) begin
        max_run = run_len;
      end
      if (out_valid && out_ready) begin
        score_output();
      end
      held      = out_valid && !out_ready;
      held_lo   = out_lo;
      held_hi   = out_hi;
      held_addr = out_addr;
      held_last = out_last;
    end
  end

  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (bp_mode == BpRandom) begin
        out_ready <= ($urandom % 3) != 0;
      end else begin
        out_ready <= 1'b1;
      end
    end
  end

  initial begin
    wait (hung);
    $display("timeout while waiting for %s", hung_what);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic send_word(word_bits_t word, logic first, logic try_cfg);
    int n;
    n = 0;
    @(posedge clk);
    in_valid  <= 1'b1;
    in_data   <= word;
    cfg_valid <= try_cfg;
    if (try_cfg) begin
      cfg_stage  <= RejectStage;
      cfg_weight <= RejectWeight;
    end
    @(negedge clk);
    if (try_cfg) begin
      check_value("cfg_busy", 128'(cfg_busy), 128'(1'b1));
    end
    while (!in_ready) begin
      if (n == WaitLimit) begin
        hung_what = "in_ready";
        hung      = 1'b1;
      end
      n++;
      @(negedge clk);
    end
    // the cycle whose closing edge makes the transfer
    if (first) begin
      first_xfer_cyc = cyc;
    end
  endtask

  task automatic wait_idle(string what);
    int n;
    n = 0;
    @(negedge clk);
    while (exp_q.size() != 0 || cfg_busy || out_valid) begin
      if (n == WaitLimit) begin
        hung_what = what;
        hung      = 1'b1;
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic write_weight(stage_idx_t stage, weight_t w);
    @(posedge clk);
    cfg_valid  <= 1'b1;
    cfg_stage  <= stage;
    cfg_weight <= w;
  endtask

  task automatic load_weights(vector_t v);
    write_weight(2'd0, v.w0);
    write_weight(2'd1, v.w1);
    write_weight(2'd2, v.w2);
    write_weight(2'd3, v.w3);
    @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  initial begin
    vector_t    v;
    word_bits_t word;
    int         errors_before;
    int         failed_tests;
    void'($urandom(32'h09c5_296b));
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    cfg_valid  = 1'b0;
    cfg_stage  = '0;
    cfg_weight = '0;
    failed_tests = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("in_ready after reset", 128'(in_ready), 128'(1'b1));
    check_value("out_valid after reset", 128'(out_valid), 128'(1'b0));
    check_value("cfg_busy after reset", 128'(cfg_busy), 128'(1'b0));

    for (int t = 0; t < NumTests; t++) begin
      v             = Vectors[t];
      errors_before = errors;
      bp_mode       = v.bp;
      wait_idle("an idle DUT before the weight load");
      if (t > 0) begin
        load_weights(v);
      end
      seen_first = 1'b0;
      max_run    = 0;
      for (int n = 0; n < `RT_FRAME_WORDS; n++) begin
        word = make_word(v.pattern, n);
        exp_q.push_back(expect_word(word, v));
        send_word(word, n == 0, v.busy_write && n == RejectAtWord);
      end
      @(posedge clk);
      in_valid  <= 1'b0;
      cfg_valid <= 1'b0;
      wait_idle("the frame to drain");
      if (v.check_timing) begin
        check_value("first word latency", 128'(first_out_cyc - first_xfer_cyc), 128'(Latency));
        check_value("out_valid run length", 128'(max_run), 128'(`RT_FRAME_WORDS));
      end
      if (errors == errors_before) begin
        $display("test %0d %s: ok", t, test_names[t]);
      end else begin
        failed_tests++;
        $display("test %0d %s: %0d errors", t, test_names[t], errors - errors_before);
      end
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             NumTests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* resnet_tail.f */
+incdir+source
+incdir+tb
source/resnet_tail_pkg.sv
source/feature_ingress.sv
source/stage_sequencer.sv
source/residual_stage.sv
source/result_egress.sv
source/resnet_tail.sv
tb/tb_resnet_tail.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_resnet_tail \
  --Mdir "$build_dir" \
  -o tb_resnet_tail \
  -f resnet_tail.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_resnet_tail" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF '*** PASSED ***' "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1
